// File: src/oflow_core_pkg.sv
`default_nettype none

package oflow_core_pkg;

	// ------------------------------
	// Feature and score widths
	// ------------------------------

	// One unsigned distance per feature
	localparam int FEATURE_LEN = 8;
	typedef logic [FEATURE_LEN-1:0] feature_t;

	// Weights share the distance width
	localparam int PRODUCT_LEN = 2 * FEATURE_LEN;
	typedef logic [PRODUCT_LEN-1:0] product_t;

	// Six products of 255 x 255 fit in 19 bits, plus one spare
	localparam int SCORE_LEN = 20;
	typedef logic [SCORE_LEN-1:0] score_t;

	// Candidate position inside a group of up to 8
	localparam int INDEX_LEN = 3;
	typedef logic [INDEX_LEN-1:0] index_t;

	// ------------------------------
	// Stream flow control
	// ------------------------------

	// Buffer entries, also the sender's starting credit
	localparam int IN_DEPTH = 4;
	localparam int IN_PTR_LEN = $clog2(IN_DEPTH);
	localparam int IN_CNT_LEN = $clog2(IN_DEPTH + 1);

	// Results the receiver can take before returning a credit
	localparam int OUT_CREDITS = 2;
	localparam int OUT_CRED_LEN = $clog2(OUT_CREDITS + 1);

endpackage

`default_nettype wire

// File: src/oflow_reg_pkg.sv
`default_nettype none

package oflow_reg_pkg;

	// ------------------------------
	// APB bus widths
	// ------------------------------
	localparam int APB_ADDR_LEN = 8;
	localparam int APB_DATA_LEN = 32;
	typedef logic [APB_ADDR_LEN-1:0] apb_addr_t;
	typedef logic [APB_DATA_LEN-1:0] apb_data_t;

	// ------------------------------
	// Configuration fields
	// ------------------------------
	localparam int WEIGHT_LEN = 8;
	typedef logic [WEIGHT_LEN-1:0] weight_t;

	// Candidates per group minus one
	localparam int GROUP_LEN = 3;
	typedef logic [GROUP_LEN-1:0] group_t;

	// New-box threshold compares against a score
	typedef oflow_core_pkg::score_t score_th_t;

	// Register map, word aligned
	localparam apb_addr_t W_IOU_ADDR = 8'h00;
	localparam apb_addr_t W_WIDTH_ADDR = 8'h04;
	localparam apb_addr_t W_HEIGHT_ADDR = 8'h08;
	localparam apb_addr_t W_COLOR1_ADDR = 8'h0C;
	localparam apb_addr_t W_COLOR2_ADDR = 8'h10;
	localparam apb_addr_t W_HISTORY_ADDR = 8'h14;
	localparam apb_addr_t NUM_OF_HISTORY_FRAMES_ADDR = 8'h18;
	localparam apb_addr_t SCORE_TH_FOR_NEW_BBOX_ADDR = 8'h1C;

endpackage

`default_nettype wire

// File: src/oflow_reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_reg_file (
	input  wire logic                       clk,
	input  wire logic                       reset_N,
	// APB slave
	input  wire logic                       apb_psel,
	input  wire logic                       apb_penable,
	input  wire logic                       apb_pwrite,
	input  wire oflow_reg_pkg::apb_addr_t   apb_addr,
	input  wire oflow_reg_pkg::apb_data_t   apb_pwdata,
	output logic                            apb_pready,
	output oflow_reg_pkg::apb_data_t        apb_prdata,
	output logic                            apb_pslverr,
	// Configuration out
	output oflow_reg_pkg::weight_t          w_iou,
	output oflow_reg_pkg::weight_t          w_w,
	output oflow_reg_pkg::weight_t          w_h,
	output oflow_reg_pkg::weight_t          w_color1,
	output oflow_reg_pkg::weight_t          w_color2,
	output oflow_reg_pkg::weight_t          w_dhistory,
	output oflow_reg_pkg::group_t           num_of_history_frame,
	output oflow_reg_pkg::score_th_t        score_th_for_new_bbox
);

	import oflow_reg_pkg::*;

	logic access;
	logic addr_hit;
	logic wr_en;

	// No wait states, every access phase completes
	assign access = apb_psel && apb_penable;
	assign apb_pready = access;

	// Known register addresses
	always_comb
	begin
		case (apb_addr)
			W_IOU_ADDR, W_WIDTH_ADDR, W_HEIGHT_ADDR, W_COLOR1_ADDR,
			W_COLOR2_ADDR, W_HISTORY_ADDR, NUM_OF_HISTORY_FRAMES_ADDR,
			SCORE_TH_FOR_NEW_BBOX_ADDR: addr_hit = 1'b1;
			default: addr_hit = 1'b0;
		endcase
	end

	assign apb_pslverr = access && !addr_hit;
	assign wr_en = access && apb_pwrite;

	// ------------------------------
	// Register writes
	// ------------------------------
	// Upper data bits dropped by the casts
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			w_iou <= '0;
			w_w <= '0;
			w_h <= '0;
			w_color1 <= '0;
			w_color2 <= '0;
			w_dhistory <= '0;
			num_of_history_frame <= '0;
			score_th_for_new_bbox <= '0;
		end
		else if (wr_en)
		begin
			case (apb_addr)
				W_IOU_ADDR: w_iou <= weight_t'(apb_pwdata);
				W_WIDTH_ADDR: w_w <= weight_t'(apb_pwdata);
				W_HEIGHT_ADDR: w_h <= weight_t'(apb_pwdata);
				W_COLOR1_ADDR: w_color1 <= weight_t'(apb_pwdata);
				W_COLOR2_ADDR: w_color2 <= weight_t'(apb_pwdata);
				W_HISTORY_ADDR: w_dhistory <= weight_t'(apb_pwdata);
				NUM_OF_HISTORY_FRAMES_ADDR: num_of_history_frame <= group_t'(apb_pwdata);
				SCORE_TH_FOR_NEW_BBOX_ADDR: score_th_for_new_bbox <= score_th_t'(apb_pwdata);
				// Unknown address, nothing changes
				default: ;
			endcase
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	// Zero outside a read access phase
	always_comb
	begin
		apb_prdata = '0;
		if (access && !apb_pwrite)
		begin
			case (apb_addr)
				W_IOU_ADDR: apb_prdata = apb_data_t'(w_iou);
				W_WIDTH_ADDR: apb_prdata = apb_data_t'(w_w);
				W_HEIGHT_ADDR: apb_prdata = apb_data_t'(w_h);
				W_COLOR1_ADDR: apb_prdata = apb_data_t'(w_color1);
				W_COLOR2_ADDR: apb_prdata = apb_data_t'(w_color2);
				W_HISTORY_ADDR: apb_prdata = apb_data_t'(w_dhistory);
				NUM_OF_HISTORY_FRAMES_ADDR: apb_prdata = apb_data_t'(num_of_history_frame);
				SCORE_TH_FOR_NEW_BBOX_ADDR: apb_prdata = apb_data_t'(score_th_for_new_bbox);
				default: apb_prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/oflow_feature_in.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_feature_in (
	input  wire logic                      clk,
	input  wire logic                      reset_N,
	// Record stream from the sender
	input  wire logic                      in_valid,
	input  wire oflow_core_pkg::feature_t  in_iou,
	input  wire oflow_core_pkg::feature_t  in_width,
	input  wire oflow_core_pkg::feature_t  in_height,
	input  wire oflow_core_pkg::feature_t  in_color1,
	input  wire oflow_core_pkg::feature_t  in_color2,
	input  wire oflow_core_pkg::feature_t  in_history,
	output logic                           in_credit,
	// Buffer head towards the metric
	input  wire logic                      metric_advance,
	output logic                           buf_valid,
	output oflow_core_pkg::feature_t       buf_iou,
	output oflow_core_pkg::feature_t       buf_width,
	output oflow_core_pkg::feature_t       buf_height,
	output oflow_core_pkg::feature_t       buf_color1,
	output oflow_core_pkg::feature_t       buf_color2,
	output oflow_core_pkg::feature_t       buf_history
);

	import oflow_core_pkg::*;

	// Six distances packed per entry
	logic [6*FEATURE_LEN-1:0] mem [IN_DEPTH];
	logic [IN_PTR_LEN-1:0] wr_ptr;
	logic [IN_PTR_LEN-1:0] rd_ptr;
	logic [IN_CNT_LEN-1:0] fill;

	// Wrap at the last entry
	function automatic logic [IN_PTR_LEN-1:0] next_ptr(input logic [IN_PTR_LEN-1:0] ptr);
		if (ptr == IN_PTR_LEN'(IN_DEPTH - 1))
			return '0;
		return ptr + IN_PTR_LEN'(1);
	endfunction

	// Entry storage
	always_ff @(posedge clk)
	begin
		if (in_valid)
			mem[wr_ptr] <= {in_iou, in_width, in_height, in_color1, in_color2, in_history};
	end

	// ------------------------------
	// Pointers and fill count
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end
		else
		begin
			if (in_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (metric_advance)
				rd_ptr <= next_ptr(rd_ptr);
			// Count moves only when one side is idle
			if (in_valid && !metric_advance)
				fill <= fill + IN_CNT_LEN'(1);
			else if (metric_advance && !in_valid)
				fill <= fill - IN_CNT_LEN'(1);
		end
	end

	// One credit back per popped record, a cycle later
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			in_credit <= 1'b0;
		else
			in_credit <= metric_advance;
	end

	// Head of buffer
	assign buf_valid = (fill != '0);
	assign {buf_iou, buf_width, buf_height, buf_color1, buf_color2, buf_history} = mem[rd_ptr];

endmodule

`default_nettype wire

// File: src/oflow_similarity_metric.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_similarity_metric (
	input  wire logic                      clk,
	input  wire logic                      reset_N,
	// Buffer head
	input  wire logic                      buf_valid,
	input  wire oflow_core_pkg::feature_t  buf_iou,
	input  wire oflow_core_pkg::feature_t  buf_width,
	input  wire oflow_core_pkg::feature_t  buf_height,
	input  wire oflow_core_pkg::feature_t  buf_color1,
	input  wire oflow_core_pkg::feature_t  buf_color2,
	input  wire oflow_core_pkg::feature_t  buf_history,
	output logic                           metric_advance,
	// Weights from the register file
	input  wire oflow_reg_pkg::weight_t    w_iou,
	input  wire oflow_reg_pkg::weight_t    w_w,
	input  wire oflow_reg_pkg::weight_t    w_h,
	input  wire oflow_reg_pkg::weight_t    w_color1,
	input  wire oflow_reg_pkg::weight_t    w_color2,
	input  wire oflow_reg_pkg::weight_t    w_dhistory,
	// Score stream
	input  wire logic                      score_ready,
	output logic                           score_valid,
	output oflow_core_pkg::score_t         score
);

	import oflow_core_pkg::*;

	logic s1_valid;
	product_t p_iou;
	product_t p_width;
	product_t p_height;
	product_t p_color1;
	product_t p_color2;
	product_t p_history;

	// Whole pipe moves as one and stage one takes the head
	assign metric_advance = buf_valid && score_ready;

	// ------------------------------
	// Stage one products
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			s1_valid <= 1'b0;
		else if (score_ready)
			s1_valid <= buf_valid;
	end

	// Six weighted distances
	always_ff @(posedge clk)
	begin
		if (score_ready)
		begin
			p_iou <= product_t'(buf_iou) * product_t'(w_iou);
			p_width <= product_t'(buf_width) * product_t'(w_w);
			p_height <= product_t'(buf_height) * product_t'(w_h);
			p_color1 <= product_t'(buf_color1) * product_t'(w_color1);
			p_color2 <= product_t'(buf_color2) * product_t'(w_color2);
			p_history <= product_t'(buf_history) * product_t'(w_dhistory);
		end
	end

	// ------------------------------
	// Stage two sum
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			score_valid <= 1'b0;
		else if (score_ready)
			score_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (score_ready)
			score <= score_t'(p_iou) + score_t'(p_width) + score_t'(p_height)
				+ score_t'(p_color1) + score_t'(p_color2) + score_t'(p_history);
	end

endmodule

`default_nettype wire

// File: src/oflow_match_select.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_match_select (
	input  wire logic                       clk,
	input  wire logic                       reset_N,
	// Score stream from the metric
	input  wire logic                       score_valid,
	input  wire oflow_core_pkg::score_t     score,
	output logic                            score_ready,
	// Configuration
	input  wire oflow_reg_pkg::group_t      num_of_history_frame,
	input  wire oflow_core_pkg::score_t     score_th_for_new_bbox,
	// Result stream, credit based
	input  wire logic                       out_credit,
	output logic                            out_valid,
	output oflow_core_pkg::score_t          out_score,
	output oflow_core_pkg::index_t          out_index,
	output logic                            out_new_bbox
);

	import oflow_core_pkg::*;

	index_t cand_cnt;
	score_t run_min;
	index_t run_idx;
	logic res_pending;
	logic [OUT_CRED_LEN-1:0] cred_cnt;

	logic accept;
	logic group_end;
	logic take_new;
	score_t grp_min;
	index_t grp_idx;

	// ------------------------------
	// Group minimum
	// ------------------------------
	// A group ends after num_of_history_frame + 1 scores
	assign group_end = (cand_cnt >= num_of_history_frame);
	assign accept = score_valid && score_ready;

	// First candidate always wins, later ones only when strictly lower
	assign take_new = (cand_cnt == '0) || (score < run_min);
	assign grp_min = take_new ? score : run_min;
	assign grp_idx = take_new ? cand_cnt : run_idx;

	// Stall only if a second result would land on an unsent one
	assign score_ready = !(res_pending && !out_valid && score_valid && group_end);

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			cand_cnt <= '0;
		else if (accept)
			cand_cnt <= group_end ? '0 : cand_cnt + index_t'(1);
	end

	// Running minimum, meaningful only inside a group
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			run_min <= grp_min;
			run_idx <= grp_idx;
		end
	end

	// ------------------------------
	// Result register and credits
	// ------------------------------
	assign out_valid = res_pending && (cred_cnt != '0);

	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			res_pending <= 1'b0;
		else if (accept && group_end)
			res_pending <= 1'b1;
		else if (out_valid)
			res_pending <= 1'b0;
	end

	// Result payload
	always_ff @(posedge clk)
	begin
		if (accept && group_end)
		begin
			out_score <= grp_min;
			out_index <= grp_idx;
			out_new_bbox <= (grp_min > score_th_for_new_bbox);
		end
	end

	// Spend on send, regain on out_credit
	always_ff @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
			cred_cnt <= OUT_CRED_LEN'(OUT_CREDITS);
		else if (out_credit && !out_valid)
			cred_cnt <= cred_cnt + OUT_CRED_LEN'(1);
		else if (out_valid && !out_credit)
			cred_cnt <= cred_cnt - OUT_CRED_LEN'(1);
	end

endmodule

`default_nettype wire

// File: src/oflow_tracker_core.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_tracker_core (
	input  wire logic                       clk,
	input  wire logic                       reset_N,
	// APB
	input  wire logic                       apb_psel,
	input  wire logic                       apb_penable,
	input  wire logic                       apb_pwrite,
	input  wire oflow_reg_pkg::apb_addr_t   apb_addr,
	input  wire oflow_reg_pkg::apb_data_t   apb_pwdata,
	output logic                            apb_pready,
	output oflow_reg_pkg::apb_data_t        apb_prdata,
	output logic                            apb_pslverr,
	// Candidate records
	input  wire logic                       in_valid,
	input  wire oflow_core_pkg::feature_t   in_iou,
	input  wire oflow_core_pkg::feature_t   in_width,
	input  wire oflow_core_pkg::feature_t   in_height,
	input  wire oflow_core_pkg::feature_t   in_color1,
	input  wire oflow_core_pkg::feature_t   in_color2,
	input  wire oflow_core_pkg::feature_t   in_history,
	// Group end marker, sender side only, groups are counted internally
	input  wire logic                       in_last,
	output logic                            in_credit,
	// Match results
	input  wire logic                       out_credit,
	output logic                            out_valid,
	output oflow_core_pkg::score_t          out_score,
	output oflow_core_pkg::index_t          out_index,
	output logic                            out_new_bbox
);

	import oflow_reg_pkg::*;
	import oflow_core_pkg::*;

	// Configuration
	weight_t w_iou;
	weight_t w_w;
	weight_t w_h;
	weight_t w_color1;
	weight_t w_color2;
	weight_t w_dhistory;
	group_t num_of_history_frame;
	score_th_t score_th_for_new_bbox;

	// Buffer head to metric
	logic buf_valid;
	logic metric_advance;
	feature_t buf_iou;
	feature_t buf_width;
	feature_t buf_height;
	feature_t buf_color1;
	feature_t buf_color2;
	feature_t buf_history;

	// Metric to match select
	logic score_valid;
	logic score_ready;
	score_t score;

	oflow_reg_file oflow_reg_file_i (
		.clk, .reset_N,
		.apb_psel, .apb_penable, .apb_pwrite, .apb_addr, .apb_pwdata,
		.apb_pready, .apb_prdata, .apb_pslverr,
		.w_iou, .w_w, .w_h, .w_color1, .w_color2, .w_dhistory,
		.num_of_history_frame, .score_th_for_new_bbox
	);

	oflow_feature_in oflow_feature_in_i (
		.clk, .reset_N,
		.in_valid, .in_iou, .in_width, .in_height,
		.in_color1, .in_color2, .in_history, .in_credit,
		.metric_advance, .buf_valid,
		.buf_iou, .buf_width, .buf_height,
		.buf_color1, .buf_color2, .buf_history
	);

	oflow_similarity_metric oflow_similarity_metric_i (
		.clk, .reset_N,
		.buf_valid, .buf_iou, .buf_width, .buf_height,
		.buf_color1, .buf_color2, .buf_history, .metric_advance,
		.w_iou, .w_w, .w_h, .w_color1, .w_color2, .w_dhistory,
		.score_ready, .score_valid, .score
	);

	oflow_match_select oflow_match_select_i (
		.clk, .reset_N,
		.score_valid, .score, .score_ready,
		.num_of_history_frame, .score_th_for_new_bbox,
		.out_credit, .out_valid, .out_score, .out_index, .out_new_bbox
	);

endmodule

`default_nettype wire

// File: bench/oflow_tracker_checker.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_tracker_checker (
	input  wire logic                      clk,
	input  wire logic                      reset_N,
	// Watched APB signals
	input  wire logic                      apb_psel,
	input  wire logic                      apb_penable,
	input  wire logic                      apb_pwrite,
	input  wire oflow_reg_pkg::apb_addr_t  apb_addr,
	input  wire oflow_reg_pkg::apb_data_t  apb_pwdata,
	input  wire logic                      apb_pready,
	input  wire oflow_reg_pkg::apb_data_t  apb_prdata,
	input  wire logic                      apb_pslverr,
	// Record stream
	input  wire logic                      in_valid,
	input  wire oflow_core_pkg::feature_t  in_iou,
	input  wire oflow_core_pkg::feature_t  in_width,
	input  wire oflow_core_pkg::feature_t  in_height,
	input  wire oflow_core_pkg::feature_t  in_color1,
	input  wire oflow_core_pkg::feature_t  in_color2,
	input  wire oflow_core_pkg::feature_t  in_history,
	input  wire logic                      in_credit,
	// Result stream
	input  wire logic                      out_credit,
	input  wire logic                      out_valid,
	input  wire oflow_core_pkg::score_t    out_score,
	input  wire oflow_core_pkg::index_t    out_index,
	input  wire logic                      out_new_bbox,
	// End of run and status
	input  wire logic                      run_done,
	output int                             error_count,
	output int                             pending
);

	import oflow_reg_pkg::*;
	import oflow_core_pkg::*;

	typedef logic [6*FEATURE_LEN-1:0] record_t;
	localparam int RESULT_LEN = SCORE_LEN + INDEX_LEN + 1;
	// {new_bbox, index, score}
	typedef logic [RESULT_LEN-1:0] result_t;

	// Configuration mirror
	weight_t weights [6];
	group_t group_size;
	score_t threshold;

	// Group being collected
	record_t group_recs [8];
	index_t group_fill;
	result_t exp_q [$];
	result_t expected;

	// Credit accounting on both streams
	int in_sent;
	int in_back;
	int out_sent;
	int out_back;
	logic final_done;

	// ------------------------------
	// Reference model
	// ------------------------------
	// Lowest weighted sum wins and the earliest index breaks a tie
	function automatic result_t expected_match(input record_t recs [8], input int count,
		input weight_t w [6], input score_t th);
		int best;
		int best_idx;
		int sum;
		best = 0;
		best_idx = 0;
		for (int i = 0; i < count; i++)
		begin
			sum = 0;
			for (int f = 0; f < 6; f++)
				sum += int'(recs[i][(5 - f) * FEATURE_LEN +: FEATURE_LEN]) * int'(w[f]);
			if (i == 0 || sum < best)
			begin
				best = sum;
				best_idx = i;
			end
		end
		return {best > int'(th), index_t'(best_idx), score_t'(best)};
	endfunction

	// Word-aligned addresses from 0x00 up to 0x1C
	function automatic logic known_addr(input apb_addr_t addr);
		return (addr[1:0] == 2'b00) && (addr <= SCORE_TH_FOR_NEW_BBOX_ADDR);
	endfunction

	function automatic apb_data_t reg_value(input apb_addr_t addr);
		if (!known_addr(addr))
			return '0;
		if (addr == NUM_OF_HISTORY_FRAMES_ADDR)
			return apb_data_t'(group_size);
		if (addr == SCORE_TH_FOR_NEW_BBOX_ADDR)
			return apb_data_t'(threshold);
		return apb_data_t'(weights[addr[4:2]]);
	endfunction

	task automatic mirror_write(input apb_addr_t addr, input apb_data_t data);
		if (addr == NUM_OF_HISTORY_FRAMES_ADDR)
			group_size = group_t'(data);
		else if (addr == SCORE_TH_FOR_NEW_BBOX_ADDR)
			threshold = score_t'(data);
		else if (known_addr(addr))
			weights[addr[4:2]] = weight_t'(data);
	endtask

	task automatic report_error(input string msg);
		$display("** Error at %0d ns: %s", $time, msg);
		error_count++;
	endtask

	task automatic report_failure(input string msg);
		$display("%s (at %0d ns)", msg, $time);
		error_count++;
	endtask

	// ------------------------------
	// Monitor and compare
	// ------------------------------
	always @(posedge clk or negedge reset_N)
	begin
		if (!reset_N)
		begin
			foreach (weights[f])
				weights[f] = '0;
			group_size = '0;
			threshold = '0;
			group_fill = '0;
			exp_q.delete();
			{in_sent, in_back, out_sent, out_back} = '0;
			error_count = 0;
			pending = 0;
			final_done = 1'b0;
		end
		else
		begin
			// APB access phase
			if (apb_psel && apb_penable)
			begin
				if (apb_pready !== 1'b1)
					report_failure("APB transfer not completed in its access phase");
				if (apb_pslverr !== !known_addr(apb_addr))
					report_error($sformatf("pslverr %b for address %h", apb_pslverr, apb_addr));
				if (!apb_pwrite && apb_prdata !== reg_value(apb_addr))
					report_error($sformatf("read %h from address %h, expected %h",
						apb_prdata, apb_addr, reg_value(apb_addr)));
				if (apb_pwrite)
					mirror_write(apb_addr, apb_pwdata);
			end

			// Accepted record needs a credit held by the sender
			if (in_valid)
			begin
				if (in_sent - in_back >= IN_DEPTH)
					report_failure("Sender exceeded the input buffer credits");
				group_recs[group_fill] = {in_iou, in_width, in_height,
					in_color1, in_color2, in_history};
				if (group_fill == group_size)
				begin
					exp_q.push_back(expected_match(group_recs, int'(group_fill) + 1,
						weights, threshold));
					group_fill = '0;
				end
				else
					group_fill = group_fill + index_t'(1);
				in_sent++;
			end
			if (in_credit)
				in_back++;

			// Result against the queue head
			if (out_valid)
			begin
				if (out_sent >= OUT_CREDITS + out_back)
					report_failure("Result sent without an output credit");
				if (exp_q.size() == 0)
					report_failure("Result reported with no group outstanding");
				else
				begin
					expected = exp_q.pop_front();
					if ({out_new_bbox, out_index, out_score} !== expected)
						report_error($sformatf("score %0d index %0d new %b, expected %0d %0d %b",
							out_score, out_index, out_new_bbox, expected[SCORE_LEN-1:0],
							expected[SCORE_LEN +: INDEX_LEN], expected[RESULT_LEN-1]));
				end
				out_sent++;
			end
			if (out_credit)
				out_back++;

			// Credit balance at the end of the run
			if (run_done && !final_done)
			begin
				final_done = 1'b1;
				if (in_back != in_sent)
					report_error($sformatf("%0d in_credit pulses for %0d records",
						in_back, in_sent));
			end
			pending = exp_q.size();
		end
	end

endmodule

`default_nettype wire

// File: bench/oflow_tracker_tb.sv
`timescale 1ns/1ps
`default_nettype none

module oflow_tracker_tb;

	import oflow_reg_pkg::*;
	import oflow_core_pkg::*;

	// Six distances, iou in the top byte
	typedef logic [6*FEATURE_LEN-1:0] record_t;

	// Single candidates, seven groups of four, four of eight, eight under back-pressure
	localparam int TOTAL_RECORDS = 6 + 7 * 4 + 4 * 8 + 8 * 4;
	localparam int CYCLE_LIMIT = TOTAL_RECORDS * 30 + 2000;

	// Group content kinds
	localparam int GRP_RANDOM = 0;
	localparam int GRP_TIE = 1;
	localparam int GRP_FIXED = 2;

	logic clk = 1'b0;
	logic reset_N;
	logic apb_psel;
	logic apb_penable;
	logic apb_pwrite;
	apb_addr_t apb_addr;
	apb_data_t apb_pwdata;
	logic apb_pready;
	apb_data_t apb_prdata;
	logic apb_pslverr;
	logic in_valid;
	feature_t in_iou;
	feature_t in_width;
	feature_t in_height;
	feature_t in_color1;
	feature_t in_color2;
	feature_t in_history;
	logic in_last;
	logic in_credit;
	logic out_credit;
	logic out_valid;
	score_t out_score;
	index_t out_index;
	logic out_new_bbox;

	// Checker handshake
	logic run_done;
	int error_count;
	int pending;

	// Environment bookkeeping
	logic hold_credits;
	int records_sent;
	int credit_pulses;
	int results_seen;
	int credits_given;
	int cycles;
	int errors_before;
	int tests_done;

	always #50 clk = ~clk;

	oflow_tracker_core oflow_tracker_core_i (.*);

	oflow_tracker_checker checker_i (.*);

	// ------------------------------
	// Environment processes
	// ------------------------------
	// Sender side credit returns
	initial
	begin
		credit_pulses = 0;
		forever
		begin
			@(posedge clk);
			if (in_credit === 1'b1)
				credit_pulses++;
		end
	end

	// Receiver, one credit back per result, randomly late or withheld
	initial
	begin
		out_credit = 1'b0;
		results_seen = 0;
		credits_given = 0;
		forever
		begin
			@(posedge clk);
			if (out_valid === 1'b1)
				results_seen++;
			@(negedge clk);
			out_credit = 1'b0;
			if (!hold_credits && results_seen > credits_given && $urandom_range(3, 0) != 0)
			begin
				out_credit = 1'b1;
				credits_given++;
			end
		end
	end

	// Run limit
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: no end of run after %0d cycles, %0d results outstanding",
			cycles, pending);
		$display("Test failed");
		$finish;
	end

	// ------------------------------
	// Stimulus tasks
	// ------------------------------
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_psel = 1'b1;
		apb_pwrite = 1'b1;
		apb_addr = addr;
		apb_pwdata = data;
		@(negedge clk);
		apb_penable = 1'b1;
		@(negedge clk);
		apb_psel = 1'b0;
		apb_penable = 1'b0;
		apb_pwrite = 1'b0;
	endtask

	// Read data is compared by the checker in the access phase
	task automatic apb_read(input apb_addr_t addr);
		apb_psel = 1'b1;
		apb_pwrite = 1'b0;
		apb_addr = addr;
		@(negedge clk);
		apb_penable = 1'b1;
		@(negedge clk);
		apb_psel = 1'b0;
		apb_penable = 1'b0;
	endtask

	// Weights packed like a record
	task automatic write_config(input record_t w, input group_t hist, input score_t th);
		for (int f = 0; f < 6; f++)
			apb_write(apb_addr_t'(4 * f), apb_data_t'(w[(5 - f) * FEATURE_LEN +: FEATURE_LEN]));
		apb_write(NUM_OF_HISTORY_FRAMES_ADDR, apb_data_t'(hist));
		apb_write(SCORE_TH_FOR_NEW_BBOX_ADDR, apb_data_t'(th));
	endtask

	function automatic record_t random_record();
		return record_t'({$urandom(), $urandom()});
	endfunction

	task automatic send_record(input record_t rec, input logic last);
		// Spend only credits actually held
		while (IN_DEPTH + credit_pulses - records_sent <= 0)
			@(negedge clk);
		{in_iou, in_width, in_height, in_color1, in_color2, in_history} = rec;
		in_last = last;
		in_valid = 1'b1;
		records_sent++;
		@(negedge clk);
		in_valid = 1'b0;
		in_last = 1'b0;
	endtask

	task automatic send_group(input int count, input int kind);
		record_t rec;
		for (int i = 0; i < count; i++)
		begin
			rec = random_record();
			// Tie: candidates 1 and 3 equal and lowest
			if (kind == GRP_TIE)
				rec = (i == 1 || i == 3) ? {6{8'h01}} : rec | {6{8'h80}};
			else if (kind == GRP_FIXED)
				rec = {6{8'h0A}};
			send_record(rec, i == count - 1);
		end
	endtask

	task automatic wait_results();
		while (pending != 0)
			@(negedge clk);
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("%-22s finished, %0d errors", name, error_count - errors_before);
		errors_before = error_count;
	endtask

	// ------------------------------
	// Test sequence
	// ------------------------------
	initial
	begin
		void'($urandom(8828));
		reset_N = 1'b0;
		apb_psel = 1'b0;
		apb_penable = 1'b0;
		apb_pwrite = 1'b0;
		apb_addr = '0;
		apb_pwdata = '0;
		in_valid = 1'b0;
		{in_iou, in_width, in_height, in_color1, in_color2, in_history} = '0;
		in_last = 1'b0;
		hold_credits = 1'b0;
		run_done = 1'b0;
		records_sent = 0;
		errors_before = 0;
		tests_done = 0;
		repeat (5) @(negedge clk);
		reset_N = 1'b1;
		@(negedge clk);

		// Reset values, then full-width writes read back masked
		for (int a = 0; a < 8; a++)
			apb_read(apb_addr_t'(4 * a));
		for (int a = 0; a < 8; a++)
			apb_write(apb_addr_t'(4 * a), $urandom() | 32'hF000_0000);
		for (int a = 0; a < 8; a++)
			apb_read(apb_addr_t'(4 * a));
		// Holes in the map leave every register alone
		apb_write(8'h20, 32'hFFFF_FFFF);
		apb_write(8'h06, 32'hFFFF_FFFF);
		apb_read(8'h20);
		apb_read(8'hFC);
		for (int a = 0; a < 8; a++)
			apb_read(apb_addr_t'(4 * a));
		finish_test("register access");

		// Group of one, full-scale weights and distances
		write_config({6{8'hFF}}, 3'd0, 20'd200000);
		send_record({6{8'hFF}}, 1'b1);
		send_record(record_t'(0), 1'b1);
		repeat (4) send_record(random_record(), 1'b1);
		wait_results();
		finish_test("single candidates");

		// Groups of four, random config, one tie group
		write_config(random_record(), 3'd3, score_t'($urandom_range(120000, 20000)));
		repeat (4) send_group(4, GRP_RANDOM);
		send_group(4, GRP_TIE);
		wait_results();
		// Unit weights, score 60 on and just above the threshold
		write_config({6{8'h01}}, 3'd3, 20'd60);
		send_group(4, GRP_FIXED);
		wait_results();
		write_config({6{8'h01}}, 3'd3, 20'd59);
		send_group(4, GRP_FIXED);
		wait_results();
		// Groups of eight
		write_config(random_record(), 3'd7, score_t'($urandom_range(120000, 20000)));
		repeat (3) send_group(8, GRP_RANDOM);
		send_group(8, GRP_TIE);
		wait_results();
		finish_test("random groups");

		// Receiver stalls, pipeline and buffer fill up
		write_config(random_record(), 3'd3, score_t'($urandom_range(120000, 20000)));
		hold_credits = 1'b1;
		fork
			repeat (8) send_group(4, GRP_RANDOM);
			begin
				repeat (300) @(negedge clk);
				hold_credits = 1'b0;
			end
		join
		wait_results();
		finish_test("output back-pressure");

		// Credit balance checked by the checker
		run_done = 1'b1;
		@(posedge clk);
		@(negedge clk);
		finish_test("input credits");

		$display("%0d tests finished, %0d errors in total", tests_done, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
src/oflow_core_pkg.sv
src/oflow_reg_pkg.sv
src/oflow_reg_file.sv
src/oflow_feature_in.sv
src/oflow_similarity_metric.sv
src/oflow_match_select.sv
src/oflow_tracker_core.sv
bench/oflow_tracker_checker.sv
bench/oflow_tracker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module oflow_tracker_tb -f vlog.f -Mdir obj_dir
./obj_dir/Voflow_tracker_tb > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure, see sim.log"
	exit 1
fi
exit 0
